//--- source/rv32_config.svh
// Fixed RV32 build values; the core has no parameters, so these are the only knobs
`ifndef RV32_CONFIG_SVH
`define RV32_CONFIG_SVH

// Data and address width
`define XLEN 32

// Architectural registers including x0
`define REG_COUNT 32

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

// ADDI x0, x0, 0 used as the bubble
`define NOP_INSTR 32'h0000_0013

`endif

//--- source/rv32IsaPkg.sv
// RV32I encodings decoded by this core only; no CSR, FENCE or sub-word memory ops
package rv32IsaPkg;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    I_OP   = 7'b0010011,   // Register-immediate ALU
    R_OP   = 7'b0110011    // Register-register ALU
  } opcodeT;

  // ALU functions, encoding is internal
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND
  } aluOpT;

  // Branch conditions, valued as funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branchT;

  // Immediate layouts
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} immFmtT;

endpackage

//--- source/rv32CorePkg.sv
// Pipeline vector types sized from rv32_config.svh only
`include "rv32_config.svh"

package rv32CorePkg;

  // Data word, also the data memory address
  typedef logic [`XLEN-1:0] wordT;

  // Instruction address
  typedef logic [`XLEN-1:0] pcT;

  // Register index
  typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;

endpackage

//--- source/fetchStage.sv
// Redirect target is taken as given, so jump targets must already be word aligned
`include "rv32_config.svh"

module fetchStage (
  input  logic            Clk,
  input  logic            arstN,
  input  logic            stall,      // Load-use bubble from decode
  input  logic            redirect,   // Taken branch or jump in Q102H
  input  rv32CorePkg::pcT target,
  output rv32CorePkg::pcT pcQ100H,    // To instruction memory
  output rv32CorePkg::pcT pcQ101H     // Address of the word now in decode
);

  // Redirect first, then stall hold, else sequential
  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      pcQ100H <= `RESET_PC;
      pcQ101H <= `RESET_PC;
    end else if (redirect || !stall) begin
      pcQ100H <= redirect ? target : pcQ100H + `XLEN'd4;
      pcQ101H <= pcQ100H;             // Follows the synchronous imem read
    end
  end

endmodule

//--- source/decodeStage.sv
// Load-use check is conservative and compares both source fields whatever the format
`include "rv32_config.svh"

module decodeStage (
  input  logic                Clk,
  input  logic                arstN,
  input  logic [31:0]         instrQ101H,      // From instruction memory
  input  rv32CorePkg::pcT     pcQ101H,
  input  logic                flushQ102H,      // Taken redirect in execute
  output logic                loadHazardQ101H, // Stall request to fetch
  output rv32CorePkg::regIdxT rs1Q101H,
  output rv32CorePkg::regIdxT rs2Q101H,
  input  rv32CorePkg::wordT   rs1DataQ101H,
  input  rv32CorePkg::wordT   rs2DataQ101H,
  output rv32CorePkg::pcT     pcQ102H,
  output rv32CorePkg::wordT   immQ102H,
  output rv32CorePkg::regIdxT rs1Q102H,
  output rv32CorePkg::regIdxT rs2Q102H,
  output rv32CorePkg::wordT   rs1DataQ102H,
  output rv32CorePkg::wordT   rs2DataQ102H,
  output rv32CorePkg::regIdxT rdQ102H,
  output rv32IsaPkg::aluOpT   aluOpQ102H,
  output rv32IsaPkg::branchT  branchQ102H,
  output logic                isBranchQ102H,
  output logic                isJumpQ102H,
  output logic                aluSelPcQ102H,   // PC as ALU input 1
  output logic                aluSelImmQ102H,  // Immediate as ALU input 2
  output logic                isLuiQ102H,
  output logic                regWrEnQ102H,
  output logic                memWrEnQ102H,
  output logic                isLoadQ102H
);
  import rv32IsaPkg::*;
  import rv32CorePkg::*;

  logic [31:0] prevInstrQ101H;   // Last raw word, replayed after the bubble
  logic [31:0] insQ101H;         // Word actually decoded
  logic        loadHazardQ102H;
  logic        flushQ103H;       // Second flush slot
  logic        fetchValidQ101H;  // First slot after reset holds a stale word
  opcodeT      opcodeQ101H;
  logic [2:0]  funct3Q101H;
  immFmtT      immFmtQ101H;
  wordT        immQ101H;
  aluOpT       aluOpQ101H;

  ////////////////////////////////////////////////////////////////////////////
  // Hazard and instruction select
  ////////////////////////////////////////////////////////////////////////////
  assign loadHazardQ101H = isLoadQ102H && (rdQ102H != '0) &&
                           ((instrQ101H[19:15] == rdQ102H) || (instrQ101H[24:20] == rdQ102H));

  always_comb begin
    if (flushQ102H || flushQ103H || loadHazardQ101H || !fetchValidQ101H)
      insQ101H = `NOP_INSTR;       // Bubble
    else if (loadHazardQ102H)
      insQ101H = prevInstrQ101H;   // PC was held, imem output moved on
    else
      insQ101H = instrQ101H;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////////////////////
  assign opcodeQ101H = opcodeT'(insQ101H[6:0]);
  assign funct3Q101H = insQ101H[14:12];
  assign rs1Q101H    = insQ101H[19:15];   // Register file read
  assign rs2Q101H    = insQ101H[24:20];

  always_comb begin
    aluOpQ101H = ADD;   // Addresses, targets, LUI pass-through
    if ((opcodeQ101H == R_OP) || (opcodeQ101H == I_OP)) begin
      case (funct3Q101H)
        3'b000:  aluOpQ101H = (insQ101H[30] && (opcodeQ101H == R_OP)) ? SUB : ADD;
        3'b001:  aluOpQ101H = SLL;
        3'b010:  aluOpQ101H = SLT;
        3'b011:  aluOpQ101H = SLTU;
        3'b100:  aluOpQ101H = XOR;
        3'b101:  aluOpQ101H = insQ101H[30] ? SRA : SRL;   // Bit 30 also in SRAI
        3'b110:  aluOpQ101H = OR;
        default: aluOpQ101H = AND;
      endcase
    end
  end

  // Immediate generator
  always_comb begin
    case (opcodeQ101H)
      STORE:      immFmtQ101H = IMM_S;
      BRANCH:     immFmtQ101H = IMM_B;
      LUI, AUIPC: immFmtQ101H = IMM_U;
      JAL:        immFmtQ101H = IMM_J;
      default:    immFmtQ101H = IMM_I;   // JALR, LOAD, I_OP
    endcase
    case (immFmtQ101H)
      IMM_S:   immQ101H = {{20{insQ101H[31]}}, insQ101H[31:25], insQ101H[11:7]};
      IMM_B:   immQ101H = {{20{insQ101H[31]}}, insQ101H[7], insQ101H[30:25],
                           insQ101H[11:8], 1'b0};
      IMM_U:   immQ101H = {insQ101H[31:12], 12'b0};
      IMM_J:   immQ101H = {{12{insQ101H[31]}}, insQ101H[19:12], insQ101H[20],
                           insQ101H[30:21], 1'b0};
      default: immQ101H = {{20{insQ101H[31]}}, insQ101H[31:20]};
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Q101H to Q102H
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      loadHazardQ102H <= 1'b0;
      flushQ103H      <= 1'b0;
      fetchValidQ101H <= 1'b0;
      rs1Q102H        <= '0;
      rs2Q102H        <= '0;
      rdQ102H         <= '0;
      aluOpQ102H      <= ADD;
      branchQ102H     <= BEQ;
      isBranchQ102H   <= 1'b0;
      isJumpQ102H     <= 1'b0;
      aluSelPcQ102H   <= 1'b0;
      aluSelImmQ102H  <= 1'b0;
      isLuiQ102H      <= 1'b0;
      regWrEnQ102H    <= 1'b0;
      memWrEnQ102H    <= 1'b0;
      isLoadQ102H     <= 1'b0;
    end else begin
      loadHazardQ102H <= loadHazardQ101H;
      flushQ103H      <= flushQ102H;
      fetchValidQ101H <= 1'b1;
      rs1Q102H        <= rs1Q101H;
      rs2Q102H        <= rs2Q101H;
      rdQ102H         <= insQ101H[11:7];
      aluOpQ102H      <= aluOpQ101H;
      branchQ102H     <= branchT'(funct3Q101H);
      isBranchQ102H   <= (opcodeQ101H == BRANCH);
      isJumpQ102H     <= (opcodeQ101H == JAL) || (opcodeQ101H == JALR);
      aluSelPcQ102H   <= opcodeQ101H inside {JAL, BRANCH, AUIPC};
      aluSelImmQ102H  <= (opcodeQ101H != R_OP);
      isLuiQ102H      <= (opcodeQ101H == LUI);
      regWrEnQ102H    <= opcodeQ101H inside {LUI, AUIPC, JAL, JALR, LOAD, I_OP, R_OP};
      memWrEnQ102H    <= (opcodeQ101H == STORE);
      isLoadQ102H     <= (opcodeQ101H == LOAD);
    end
  end

  // Payload
  always_ff @(posedge Clk) begin
    prevInstrQ101H <= instrQ101H;
    pcQ102H        <= pcQ101H;
    immQ102H       <= immQ101H;
    rs1DataQ102H   <= rs1DataQ101H;
    rs2DataQ102H   <= rs2DataQ101H;
  end

endmodule

//--- source/regFile.sv
// Registers clear on reset; a Q104H write is visible to a read in the same cycle
`include "rv32_config.svh"

module regFile (
  input  logic                Clk,
  input  logic                arstN,
  input  rv32CorePkg::regIdxT rs1,
  input  rv32CorePkg::regIdxT rs2,
  output rv32CorePkg::wordT   rs1Data,
  output rv32CorePkg::wordT   rs2Data,
  input  logic                wrEn,     // From write-back
  input  rv32CorePkg::regIdxT rd,
  input  rv32CorePkg::wordT   wrData
);
  import rv32CorePkg::*;

  wordT [`REG_COUNT-1:1] regs;   // Nothing behind x0

  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN)
      regs <= '0;
    else if (wrEn && (rd != '0))
      regs[rd] <= wrData;
  end

  // Zero for x0, then write-through, then array
  function automatic wordT readReg(regIdxT idx);
    if (idx == '0)
      return '0;
    if (wrEn && (rd == idx))
      return wrData;
    return regs[idx];
  endfunction

  always_comb begin
    rs1Data = readReg(rs1);
    rs2Data = readReg(rs2);
  end

endmodule

//--- source/executeStage.sv
// Forwards from Q103H and Q104H only; a load still in Q103H is covered by the decode stall
`include "rv32_config.svh"

module executeStage (
  input  logic                Clk,
  input  logic                arstN,
  input  rv32CorePkg::pcT     pcQ102H,
  input  rv32CorePkg::wordT   immQ102H,
  input  rv32CorePkg::regIdxT rs1Q102H,
  input  rv32CorePkg::regIdxT rs2Q102H,
  input  rv32CorePkg::wordT   rs1DataQ102H,
  input  rv32CorePkg::wordT   rs2DataQ102H,
  input  rv32CorePkg::regIdxT rdQ102H,
  input  rv32IsaPkg::aluOpT   aluOpQ102H,
  input  rv32IsaPkg::branchT  branchQ102H,
  input  logic                isBranchQ102H,
  input  logic                isJumpQ102H,
  input  logic                aluSelPcQ102H,
  input  logic                aluSelImmQ102H,
  input  logic                isLuiQ102H,
  input  logic                regWrEnQ102H,
  input  logic                memWrEnQ102H,
  input  logic                isLoadQ102H,
  input  rv32CorePkg::wordT   fwdDataQ103H,   // ALU result one stage ahead
  input  rv32CorePkg::regIdxT fwdRdQ103H,
  input  logic                fwdWrEnQ103H,
  input  rv32CorePkg::wordT   fwdDataQ104H,   // Final write-back data
  input  rv32CorePkg::regIdxT fwdRdQ104H,
  input  logic                fwdWrEnQ104H,
  output logic                redirectQ102H,  // To fetch and decode
  output rv32CorePkg::wordT   aluOutQ102H,    // Also the redirect target
  output rv32CorePkg::wordT   aluOutQ103H,
  output rv32CorePkg::wordT   storeDataQ103H,
  output rv32CorePkg::regIdxT rdQ103H,
  output logic                regWrEnQ103H,
  output logic                memWrEnQ103H,
  output logic                isLoadQ103H,
  output logic                isJumpQ103H,
  output rv32CorePkg::pcT     pcPlus4Q103H
);
  import rv32IsaPkg::*;
  import rv32CorePkg::*;

  wordT fwdResQ103H;   // Register value of the Q103H instruction
  wordT op1Q102H;
  wordT op2Q102H;
  wordT aluIn1Q102H;
  wordT aluIn2Q102H;
  pcT   pcPlus4Q102H;
  logic takenQ102H;

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////////////////////////////////////////
  assign fwdResQ103H = isJumpQ103H ? pcPlus4Q103H : fwdDataQ103H;   // Link, not target

  // Youngest producer wins, never for x0
  function automatic wordT fwdSel(regIdxT rs, wordT regData);
    if ((rs != '0) && fwdWrEnQ103H && (rs == fwdRdQ103H))
      return fwdResQ103H;
    if ((rs != '0) && fwdWrEnQ104H && (rs == fwdRdQ104H))
      return fwdDataQ104H;
    return regData;
  endfunction

  always_comb begin
    op1Q102H = fwdSel(rs1Q102H, rs1DataQ102H);
    op2Q102H = fwdSel(rs2Q102H, rs2DataQ102H);
  end

  ////////////////////////////////////////////////////////////////////////////
  // ALU and branch
  ////////////////////////////////////////////////////////////////////////////
  assign aluIn1Q102H  = aluSelPcQ102H ? pcQ102H : op1Q102H;
  assign aluIn2Q102H  = aluSelImmQ102H ? immQ102H : op2Q102H;
  assign pcPlus4Q102H = pcQ102H + `XLEN'd4;

  always_comb begin
    case (aluOpQ102H)
      SUB:     aluOutQ102H = aluIn1Q102H - aluIn2Q102H;
      SLL:     aluOutQ102H = aluIn1Q102H << aluIn2Q102H[4:0];
      SLT:     aluOutQ102H = wordT'($signed(aluIn1Q102H) < $signed(aluIn2Q102H));
      SLTU:    aluOutQ102H = wordT'(aluIn1Q102H < aluIn2Q102H);
      XOR:     aluOutQ102H = aluIn1Q102H ^ aluIn2Q102H;
      SRL:     aluOutQ102H = aluIn1Q102H >> aluIn2Q102H[4:0];
      SRA:     aluOutQ102H = wordT'($signed(aluIn1Q102H) >>> aluIn2Q102H[4:0]);
      OR:      aluOutQ102H = aluIn1Q102H | aluIn2Q102H;
      AND:     aluOutQ102H = aluIn1Q102H & aluIn2Q102H;
      default: aluOutQ102H = aluIn1Q102H + aluIn2Q102H;   // ADD and address math
    endcase
    if (isLuiQ102H)
      aluOutQ102H = aluIn2Q102H;   // Upper immediate as is
  end

  // Compare uses forwarded operands, not ALU inputs
  always_comb begin
    case (branchQ102H)
      BEQ:     takenQ102H = (op1Q102H == op2Q102H);
      BNE:     takenQ102H = (op1Q102H != op2Q102H);
      BLT:     takenQ102H = ($signed(op1Q102H) < $signed(op2Q102H));
      BGE:     takenQ102H = ($signed(op1Q102H) >= $signed(op2Q102H));
      BLTU:    takenQ102H = (op1Q102H < op2Q102H);
      BGEU:    takenQ102H = (op1Q102H >= op2Q102H);
      default: takenQ102H = 1'b0;
    endcase
  end

  assign redirectQ102H = isJumpQ102H || (isBranchQ102H && takenQ102H);

  ////////////////////////////////////////////////////////////////////////////
  // Q102H to Q103H
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      rdQ103H      <= '0;
      regWrEnQ103H <= 1'b0;
      memWrEnQ103H <= 1'b0;
      isLoadQ103H  <= 1'b0;
      isJumpQ103H  <= 1'b0;
    end else begin
      rdQ103H      <= rdQ102H;
      regWrEnQ103H <= regWrEnQ102H;
      memWrEnQ103H <= memWrEnQ102H;
      isLoadQ103H  <= isLoadQ102H;
      isJumpQ103H  <= isJumpQ102H;
    end
  end

  always_ff @(posedge Clk) begin
    aluOutQ103H    <= aluOutQ102H;
    storeDataQ103H <= op2Q102H;   // Forwarded rs2
    pcPlus4Q103H   <= pcPlus4Q102H;
  end

endmodule

//--- source/memWriteback.sv
// Word accesses only; the data memory must answer the cycle after dMemRdEnQ103H
module memWriteback (
  input  logic                Clk,
  input  logic                arstN,
  input  rv32CorePkg::wordT   aluOutQ103H,
  input  rv32CorePkg::wordT   storeDataQ103H,
  input  rv32CorePkg::regIdxT rdQ103H,
  input  logic                regWrEnQ103H,
  input  logic                memWrEnQ103H,
  input  logic                isLoadQ103H,
  input  logic                isJumpQ103H,
  input  rv32CorePkg::pcT     pcPlus4Q103H,
  output rv32CorePkg::wordT   dMemAddrQ103H,
  output rv32CorePkg::wordT   dMemWrDataQ103H,
  output logic                dMemWrEnQ103H,
  output logic                dMemRdEnQ103H,
  input  rv32CorePkg::wordT   dMemRdDataQ104H,
  output logic                wrEnQ104H,     // Register file write port
  output rv32CorePkg::regIdxT rdQ104H,
  output rv32CorePkg::wordT   wrDataQ104H
);
  import rv32CorePkg::*;

  logic isLoadQ104H;
  logic isJumpQ104H;
  wordT aluOutQ104H;
  pcT   pcPlus4Q104H;

  // Memory strobes straight from Q103H
  assign dMemAddrQ103H   = aluOutQ103H;
  assign dMemWrDataQ103H = storeDataQ103H;
  assign dMemWrEnQ103H   = memWrEnQ103H;
  assign dMemRdEnQ103H   = isLoadQ103H;

  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      wrEnQ104H   <= 1'b0;
      rdQ104H     <= '0;
      isLoadQ104H <= 1'b0;
      isJumpQ104H <= 1'b0;
    end else begin
      wrEnQ104H   <= regWrEnQ103H;
      rdQ104H     <= rdQ103H;
      isLoadQ104H <= isLoadQ103H;
      isJumpQ104H <= isJumpQ103H;
    end
  end

  always_ff @(posedge Clk) begin
    aluOutQ104H  <= aluOutQ103H;
    pcPlus4Q104H <= pcPlus4Q103H;
  end

  // Link address, load data, else ALU
  assign wrDataQ104H = isJumpQ104H ? pcPlus4Q104H :
                       isLoadQ104H ? dMemRdDataQ104H : aluOutQ104H;

endmodule

//--- source/rv32Core.sv
// Both memories have a one-cycle read and are always ready; no byte enables on the data side
module rv32Core (
  input  logic              Clk,
  input  logic              arstN,
  output rv32CorePkg::pcT   pcQ100H,          // To instruction memory
  input  logic [31:0]       instrQ101H,       // From instruction memory
  output rv32CorePkg::wordT dMemAddrQ103H,
  output rv32CorePkg::wordT dMemWrDataQ103H,
  output logic              dMemWrEnQ103H,
  output logic              dMemRdEnQ103H,
  input  rv32CorePkg::wordT dMemRdDataQ104H
);
  import rv32IsaPkg::*;
  import rv32CorePkg::*;

  // Fetch and decode
  pcT     pcQ101H;
  logic   loadHazardQ101H;
  regIdxT rs1Q101H;
  regIdxT rs2Q101H;
  wordT   rs1DataQ101H;
  wordT   rs2DataQ101H;
  // Q102H bundle
  pcT     pcQ102H;
  wordT   immQ102H;
  regIdxT rs1Q102H;
  regIdxT rs2Q102H;
  wordT   rs1DataQ102H;
  wordT   rs2DataQ102H;
  regIdxT rdQ102H;
  aluOpT  aluOpQ102H;
  branchT branchQ102H;
  logic   isBranchQ102H;
  logic   isJumpQ102H;
  logic   aluSelPcQ102H;
  logic   aluSelImmQ102H;
  logic   isLuiQ102H;
  logic   regWrEnQ102H;
  logic   memWrEnQ102H;
  logic   isLoadQ102H;
  logic   redirectQ102H;
  wordT   aluOutQ102H;
  // Q103H bundle
  wordT   aluOutQ103H;
  wordT   storeDataQ103H;
  regIdxT rdQ103H;
  logic   regWrEnQ103H;
  logic   memWrEnQ103H;
  logic   isLoadQ103H;
  logic   isJumpQ103H;
  pcT     pcPlus4Q103H;
  // Write-back
  logic   wrEnQ104H;
  regIdxT rdQ104H;
  wordT   wrDataQ104H;

  fetchStage i_fetchStage (
    .stall    (loadHazardQ101H),
    .redirect (redirectQ102H),
    .target   (aluOutQ102H),
    .*
  );

  decodeStage i_decodeStage (
    .flushQ102H (redirectQ102H),
    .*
  );

  regFile i_regFile (
    .Clk     (Clk),
    .arstN   (arstN),
    .rs1     (rs1Q101H),
    .rs2     (rs2Q101H),
    .rs1Data (rs1DataQ101H),
    .rs2Data (rs2DataQ101H),
    .wrEn    (wrEnQ104H),
    .rd      (rdQ104H),
    .wrData  (wrDataQ104H)
  );

  executeStage i_executeStage (
    .fwdDataQ103H (aluOutQ103H),
    .fwdRdQ103H   (rdQ103H),
    .fwdWrEnQ103H (regWrEnQ103H),
    .fwdDataQ104H (wrDataQ104H),
    .fwdRdQ104H   (rdQ104H),
    .fwdWrEnQ104H (wrEnQ104H),
    .*
  );

  memWriteback i_memWriteback (.*);

endmodule

//--- bench/rv32Core_sva.sv
// Port and stall checks, bound into every rv32Core; silent while reset is low
module rv32Core_sva (
  input logic            Clk,
  input logic            arstN,
  input rv32CorePkg::pcT pcQ100H,
  input logic            dMemWrEnQ103H,
  input logic            dMemRdEnQ103H,
  input logic            loadHazardQ101H   // Internal to the core
);

  // One data access per cycle
  strobesExclusive: assert property (@(posedge Clk) disable iff (!arstN)
    !(dMemWrEnQ103H && dMemRdEnQ103H))
    else $error("Data memory read and write strobes high together");

  pcAligned: assert property (@(posedge Clk) disable iff (!arstN) pcQ100H[1:0] == 2'b00)
    else $error("pcQ100H is not word aligned");

  // Bubble keeps the fetch address
  hazardHoldsPc: assert property (@(posedge Clk) disable iff (!arstN)
    loadHazardQ101H |=> $stable(pcQ100H))
    else $error("pcQ100H moved during a load-use stall");

endmodule

bind rv32Core rv32Core_sva i_rv32Core_sva (.*);

//--- bench/rv32CoreTb.sv
// Random RV32I programs on x0..x7 with forward control flow only; each run ends in a self jump
`include "rv32_config.svh"

module rv32CoreTb;
  import rv32IsaPkg::*;

  localparam int ImemWords = 1024;
  localparam int DmemWords = 64;

  logic              Clk;
  logic              arstN;
  logic [`XLEN-1:0]  pcQ100H;
  logic [31:0]       instrQ101H;
  logic [`XLEN-1:0]  dMemAddrQ103H;
  logic [`XLEN-1:0]  dMemWrDataQ103H;
  logic              dMemWrEnQ103H;
  logic              dMemRdEnQ103H;
  logic [`XLEN-1:0]  dMemRdDataQ104H;

  logic [31:0]       imem [ImemWords];
  logic [`XLEN-1:0]  dmem [DmemWords];
  logic [`XLEN-1:0]  refMem [DmemWords];    // Model view of data memory
  logic [`XLEN-1:0]  refRegs [32];          // Only x0..x7 ever used
  logic [63:0]       expQ [$];              // {address, data} per expected store
  logic [31:0]       lcgState;
  int                progLen;
  logic              live;                  // Model executes what is emitted
  logic [5:0]        slot;                  // Next store word
  logic [9:0]        fetchIdx;
  logic [5:0]        dIdx;
  logic              rdEn;
  logic              wrEn;
  logic [`XLEN-1:0]  wrData;

  rv32Core i_rv32Core (.*);

  initial begin
    Clk = 1'b0;
    forever #5 Clk = ~Clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers and reporting
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic int unsigned pick(int unsigned n);
    logic [31:0] r;
    r = lcgNext();
    return (r >> 8) % n;   // Upper bits, low LCG bits are weak
  endfunction

  function automatic logic [31:0] randWord();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcgNext();
    lo = lcgNext();
    return {hi[31:16], lo[31:16]};
  endfunction

  task automatic failRun(string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic compare(logic [31:0] actual, logic [31:0] expected, string what);
    if (actual !== expected)
      failRun($sformatf("Error at time %0t: %s mismatch, got %h, expected %h",
                        $time, what, actual, expected));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Encoder and ISA model
  ////////////////////////////////////////////////////////////////////////////
  // R format goes through IMM_I with imm = {funct7, rs2}
  function automatic logic [31:0] encode(opcodeT op, immFmtT fmt, logic [4:0] rd,
                                         logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [31:0] imm);
    case (fmt)
      IMM_S:   return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
      IMM_B:   return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
      IMM_U:   return {imm[31:12], rd, op};
      IMM_J:   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
      default: return {imm[11:0], rs1, f3, rd, op};
    endcase
  endfunction

  function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] a,
                                         logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic void emit(logic [31:0] instr);
    imem[progLen[9:0]] = instr;
    progLen++;
  endfunction

  function automatic logic [31:0] curPc();
    return 32'(progLen) << 2;   // Address of the next emitted word
  endfunction

  function automatic void setReg(logic [4:0] r, logic [31:0] v);
    if (live && (r != 5'd0))
      refRegs[r] = v;
  endfunction

  function automatic void genStore(logic [4:0] rs);
    logic [31:0] addr;
    addr = {24'b0, slot, 2'b00};   // Absolute, base x0
    emit(encode(STORE, IMM_S, 5'd0, 3'b010, 5'd0, rs, addr));
    if (live) begin
      refMem[slot] = refRegs[rs];
      expQ.push_back({addr, refRegs[rs]});
    end
    slot = slot + 6'd1;
  endfunction

  // Slots after a branch or jump, executed only when not skipped
  function automatic void genShadow(logic skipped, int unsigned n);
    live = !skipped;
    for (int unsigned k = 0; k < n; k++)
      genStore(5'(pick(8)));
    live = 1'b1;
  endfunction

  function automatic void genAlu();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [31:0] imm;
    logic [31:0] r;
    rd  = 5'(pick(8));   // x0 sometimes, result dropped
    rs1 = 5'(pick(8));
    rs2 = 5'(pick(8));
    f3  = 3'(pick(8));
    alt = ((f3 == 3'd0) || (f3 == 3'd5)) && (pick(2) == 1);
    if (pick(2) == 0) begin   // Register-register
      emit(encode(R_OP, IMM_I, rd, f3, rs1, 5'd0, {20'b0, 1'b0, alt, 5'b0, rs2}));
      setReg(rd, aluRef(f3, alt, refRegs[rs1], refRegs[rs2]));
    end else begin
      r = randWord();
      if ((f3 == 3'd1) || (f3 == 3'd5))
        imm = {20'b0, 1'b0, alt && (f3 == 3'd5), 5'b0, r[4:0]};   // Shift amount
      else
        imm = {{20{r[11]}}, r[11:0]};
      emit(encode(I_OP, IMM_I, rd, f3, rs1, 5'd0, imm));
      setReg(rd, aluRef(f3, alt && (f3 == 3'd5), refRegs[rs1], imm));
    end
  endfunction

  function automatic void genUpper();
    logic [4:0]  rd;
    logic [31:0] imm;
    logic        isAuipc;
    rd      = 5'(pick(7) + 1);
    imm     = randWord() & 32'hffff_f000;
    isAuipc = (pick(2) == 1);
    setReg(rd, isAuipc ? curPc() + imm : imm);
    emit(encode(isAuipc ? AUIPC : LUI, IMM_U, rd, 3'd0, 5'd0, 5'd0, imm));
    genStore(rd);
  endfunction

  // Store, reload the same word, use it at once
  function automatic void genLoadUse();
    logic [4:0]  rd;
    logic [4:0]  rd2;
    logic [31:0] addr;
    logic [31:0] imm;
    rd   = 5'(pick(7) + 1);
    rd2  = 5'(pick(7) + 1);
    addr = {24'b0, slot, 2'b00};
    imm  = 32'(pick(256));
    genStore(5'(pick(8)));
    emit(encode(LOAD, IMM_I, rd, 3'b010, 5'd0, 5'd0, addr));
    setReg(rd, refMem[addr[7:2]]);
    emit(encode(I_OP, IMM_I, rd2, 3'd0, rd, 5'd0, imm));
    setReg(rd2, refRegs[rd] + imm);
    genStore(rd2);
  endfunction

  function automatic void genBranch();
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic        taken;
    int unsigned skip;
    f3 = 3'(pick(6));
    if (f3 >= 3'd2)
      f3 = f3 + 3'd2;   // Skip the unused funct3 codes 2 and 3
    rs1 = 5'(pick(8));
    rs2 = (pick(4) == 0) ? rs1 : 5'(pick(8));   // Force equal operands now and then
    a = refRegs[rs1];
    b = refRegs[rs2];
    case (f3)
      3'd0:    taken = (a == b);
      3'd1:    taken = (a != b);
      3'd4:    taken = ($signed(a) < $signed(b));
      3'd5:    taken = ($signed(a) >= $signed(b));
      3'd6:    taken = (a < b);
      default: taken = (a >= b);
    endcase
    skip = pick(3) + 1;
    emit(encode(BRANCH, IMM_B, 5'd0, f3, rs1, rs2, 32'((skip + 1) * 4)));
    genShadow(taken, skip);
  endfunction

  function automatic void genJump();
    logic [4:0]  rd;
    logic [4:0]  rt;
    int unsigned skip;
    rd   = 5'(pick(7) + 1);
    rt   = 5'(pick(7) + 1);
    skip = pick(3) + 1;
    if (pick(2) == 0) begin
      setReg(rd, curPc() + 32'd4);
      emit(encode(JAL, IMM_J, rd, 3'd0, 5'd0, 5'd0, 32'((skip + 1) * 4)));
    end else begin   // AUIPC base, then JALR over the shadow
      setReg(rt, curPc());
      emit(encode(AUIPC, IMM_U, rt, 3'd0, 5'd0, 5'd0, 32'd0));
      setReg(rd, curPc() + 32'd4);
      emit(encode(JALR, IMM_I, rd, 3'd0, rt, 5'd0, 32'((skip + 2) * 4)));
    end
    genShadow(1'b1, skip);
    genStore(rd);   // Link value
  endfunction

  function automatic void buildProgram();
    for (int round = 0; round < 6; round++) begin
      for (int k = 0; k < 8; k++)
        genAlu();
      for (int r = 0; r < 8; r++)
        genStore(5'(r));
      for (int k = 0; k < 10; k++) begin
        case (pick(5))
          0:       genAlu();
          1:       genUpper();
          2:       genLoadUse();
          3:       genBranch();
          default: genJump();
        endcase
      end
    end
    for (int r = 0; r < 8; r++)
      genStore(5'(r));
    emit(encode(JAL, IMM_J, 5'd0, 3'd0, 5'd0, 5'd0, 32'd0));   // Park here
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Memories and store checker
  ////////////////////////////////////////////////////////////////////////////
  task automatic checkStore(logic [31:0] addr, logic [31:0] data);
    logic [63:0] exp;
    if (expQ.size() == 0) begin
      failRun("Unexpected store at the data memory port, none was expected");
    end else begin
      exp = expQ.pop_front();
      compare(addr, exp[63:32], "store address");
      compare(data, exp[31:0], "store data");
    end
  endtask

  always begin
    @(negedge Clk);   // Outputs settled
    fetchIdx = pcQ100H[11:2];
    dIdx     = dMemAddrQ103H[7:2];
    rdEn     = dMemRdEnQ103H;
    wrEn     = dMemWrEnQ103H;
    wrData   = dMemWrDataQ103H;
    if (arstN && wrEn)
      checkStore(dMemAddrQ103H, wrData);
    @(posedge Clk);
    #1;
    instrQ101H = imem[fetchIdx];   // Registered read
    if (rdEn)
      dMemRdDataQ104H = dmem[dIdx];
    if (wrEn)
      dmem[dIdx] = wrData;
  end

  initial begin
    arstN           = 1'b0;
    instrQ101H      = `NOP_INSTR;
    dMemRdDataQ104H = '0;
    lcgState        = 32'hca6b;
    progLen         = 0;
    live            = 1'b1;
    slot            = '0;
    for (int i = 0; i < ImemWords; i++)
      imem[i[9:0]] = `NOP_INSTR;
    for (int i = 0; i < DmemWords; i++) begin
      dmem[i[5:0]]   = 32'(i) * 32'h9e37_79b9 + 32'h0bad_0000;   // Per-word pattern
      refMem[i[5:0]] = 32'(i) * 32'h9e37_79b9 + 32'h0bad_0000;
    end
    for (int r = 0; r < 32; r++)
      refRegs[r[4:0]] = '0;
    buildProgram();
    repeat (10) @(posedge Clk);
    #1 arstN = 1'b1;
    while (expQ.size() != 0)
      @(posedge Clk);
    repeat (10) @(posedge Clk);   // Room for a stray store to show up
    $display("test passed");
    $finish;
  end

  // Watchdog, 20 cycles per instruction plus reset
  initial begin
    #1;
    repeat (20 * progLen + 40) @(posedge Clk);
    failRun("Timeout: the core did not finish the program in time");
  end

endmodule

//--- sim.f
+incdir+source
source/rv32IsaPkg.sv
source/rv32CorePkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/regFile.sv
source/executeStage.sv
source/memWriteback.sv
source/rv32Core.sv
bench/rv32Core_sva.sv
bench/rv32CoreTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = rv32CoreTb
FILELIST = sim.f
EXE      = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(EXE))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
